//--- Makefile
TOP = chess_tb

all: run

build:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o V$(TOP)

# The simulation passes only if the pass line shows up in its output
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module chess_board_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- dv/chess_tb.sv
// Chess board model testbench
`timescale 1ns/1ps
`default_nettype none

module chess_tb import chess_pkg::*; ();

  localparam logic [2:0] OP_INIT     = 3'd0;
  localparam logic [2:0] OP_MOVE     = 3'd1;
  localparam logic [2:0] OP_BURST    = 3'd2;  // Second MOVE while busy
  localparam logic [2:0] OP_STATUS   = 3'd3;
  localparam logic [2:0] OP_SQUARE   = 3'd4;
  localparam logic [2:0] OP_UNMAPPED = 3'd5;

  typedef struct packed {
    logic [2:0] op;
    sq_idx_t    org;
    sq_idx_t    dst;
    logic       ok;   // Move expected to be accepted
    logic       err;  // pslverr expected
  } step_t;

  logic        clk;
  logic        rst_n;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  step_t   steps [$];
  square_u ref_board [64];
  logic    ref_player;
  logic    ref_ok;
  logic    ref_over;
  logic    ref_winner;
  int      seed;

  chess_board_top i_chess_board_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_square(input square_u got, input square_u exp, input string what);
    if (got.code !== exp.code) begin
      stop_run($sformatf("MISMATCH at %0t ns: %s read %h, expected %h",
                         $time, what, got.code, exp.code));
    end
  endtask

  task automatic check_status(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t ns: status %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_waits(input int got, input int exp, input string what);
    if (got != exp) begin
      stop_run($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
                         $time, what, got, exp));
    end
  endtask

  // "e2" style name to square index
  function automatic sq_idx_t square_index(input string name);
    int f;
    int r;
    f = int'(name[0]) - 97;
    r = int'(name[1]) - 49;
    return sq_idx_t'(f * 8 + r);
  endfunction

  function automatic square_u start_square(input sq_idx_t idx);
    logic [2:0] back [8];
    square_u    s;
    back = '{KIND_ROOK, KIND_KNIGHT, KIND_BISHOP, KIND_QUEEN,
             KIND_KING, KIND_BISHOP, KIND_KNIGHT, KIND_ROOK};
    s.code = 4'h0;
    s.pc.white = (idx[2:0] < 3'd2);  // White holds ranks 1 and 2
    if (idx[2:0] == 3'd0 || idx[2:0] == 3'd7) begin
      s.pc.kind = back[idx[5:3]];
    end else if (idx[2:0] == 3'd1 || idx[2:0] == 3'd6) begin
      s.pc.kind = KIND_PAWN;
    end
    return s;
  endfunction

  // Rules applied to the reference board without path blocking
  function automatic logic move_legal(input sq_idx_t org, input sq_idx_t dst);
    square_u p;
    square_u c;
    int      df;
    int      dr;
    int      af;
    int      ar;
    int      step;
    p    = ref_board[org];
    c    = ref_board[dst];
    df   = int'(dst[5:3]) - int'(org[5:3]);
    dr   = int'(dst[2:0]) - int'(org[2:0]);
    af   = (df < 0) ? -df : df;
    ar   = (dr < 0) ? -dr : dr;
    step = ref_player ? 1 : -1;
    if (p.pc.kind == KIND_EMPTY || p.pc.white != ref_player) return 1'b0;
    if (c.pc.kind != KIND_EMPTY && c.pc.white == ref_player) return 1'b0;
    case (p.pc.kind)
      KIND_PAWN:   return (dr == step) && ((af == 0 && c.pc.kind == KIND_EMPTY) ||
                                           (af == 1 && c.pc.kind != KIND_EMPTY));
      KIND_KNIGHT: return (af * ar == 2);
      KIND_BISHOP: return (af == ar) && (af != 0);
      KIND_ROOK:   return (af == 0) != (ar == 0);
      KIND_QUEEN:  return ((af == ar) && (af != 0)) || ((af == 0) != (ar == 0));
      KIND_KING:   return (af <= 1) && (ar <= 1) && (af + ar != 0);
      default:     return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] expected_status();
    logic [31:0] e;
    e            = '0;
    e[ST_PLAYER] = ref_player;
    e[ST_OK]     = ref_ok;
    e[ST_OVER]   = ref_over;
    e[ST_WINNER] = ref_winner;
    return e;  // Busy is always low once a step settles
  endfunction

  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          input int exp_waits, output logic [31:0] rdata, output logic err);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #1;
    while (!pready) begin  // Board reads add one wait state
      if (cycles == 8) begin
        stop_run($sformatf("Timeout at %0t ns: no pready for address %h", $time, addr));
      end
      cycles++;
      @(posedge clk);
      #3;
    end
    check_waits(cycles, exp_waits, $sformatf("wait states at address %h", addr));
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rd_ignored;
    logic        err;
    apb_xfer(1'b1, addr, data, 0, rd_ignored, err);
    check_err(err, exp_err, $sformatf("pslverr on write to %h", addr));
  endtask

  task automatic read_status_word(output logic [31:0] st);
    logic err;
    apb_xfer(1'b0, REG_STATUS, 32'd0, 0, st, err);
    check_err(err, 1'b0, "pslverr on status read");
  endtask

  task automatic verify_status();
    logic [31:0] st;
    read_status_word(st);
    check_status(st, expected_status());
  endtask

  task automatic verify_square(input sq_idx_t idx);
    logic [31:0] rd;
    logic        err;
    square_u     got;
    apb_xfer(1'b0, REG_BOARD_BASE + {4'd0, idx, 2'b00}, 32'd0, 1, rd, err);
    check_err(err, 1'b0, "pslverr on board read");
    got.code = rd[3:0];
    check_square(got, ref_board[idx], $sformatf("square %0d", idx));
  endtask

  task automatic verify_board_random();
    sq_idx_t order [64];
    sq_idx_t tmp;
    int      j;
    for (int i = 0; i < 64; i++) begin
      order[i] = sq_idx_t'(i);
    end
    for (int i = 63; i > 0; i--) begin  // Shuffle the read order
      j        = int'($unsigned($random(seed)) % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 64; i++) begin
      verify_square(order[i]);
    end
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int          polls;
    polls = 0;
    read_status_word(st);
    while (st[ST_BUSY]) begin
      if (polls == 100) begin
        stop_run($sformatf("Timeout at %0t ns: the board stayed busy", $time));
      end
      polls++;
      read_status_word(st);
    end
  endtask

  task automatic apply_move(input sq_idx_t org, input sq_idx_t dst, input logic ok);
    ref_ok = ok;
    if (ok) begin
      if (ref_board[dst].pc.kind == KIND_KING) begin
        ref_over   = 1'b1;
        ref_winner = ref_player;
      end
      ref_board[dst]      = ref_board[org];
      ref_board[org].code = 4'h0;
      ref_player          = ~ref_player;
    end
  endtask

  task automatic run_step(input int n, input step_t s);
    logic [31:0] rd;
    logic        err;
    logic        live;  // Move actually reaches the pipeline
    live = (s.op == OP_BURST) || !s.err;
    case (s.op)
      OP_INIT: begin
        write_reg(REG_CTRL, 32'd1, s.err);
        wait_idle();
        for (int i = 0; i < 64; i++) begin
          ref_board[i] = start_square(sq_idx_t'(i));
        end
        ref_player = 1'b1;
        ref_over   = 1'b0;
        ref_winner = 1'b0;
        verify_status();
        verify_board_random();
      end
      OP_MOVE, OP_BURST: begin
        if (live && move_legal(s.org, s.dst) != s.ok) begin
          stop_run($sformatf("Table entry %0d does not agree with the chess rules", n));
        end
        write_reg(REG_MOVE, {20'd0, s.dst, s.org}, (s.op == OP_BURST) ? 1'b0 : s.err);
        if (s.op == OP_BURST) begin
          write_reg(REG_MOVE, {20'd0, s.dst, s.org}, s.err);
        end
        if (live) begin
          wait_idle();
          apply_move(s.org, s.dst, s.ok);
          verify_square(s.org);
          verify_square(s.dst);
        end
        verify_status();
      end
      OP_STATUS: verify_status();
      OP_SQUARE: verify_square(s.org);
      default: begin
        apb_xfer(1'b0, 12'h00C, 32'd0, 0, rd, err);
        check_err(err, s.err, "pslverr on unmapped read");
      end
    endcase
  endtask

  task automatic add_step(input logic [2:0] op, input string o, input string d,
                          input logic ok, input logic err);
    step_t s;
    s.op  = op;
    s.org = square_index(o);
    s.dst = square_index(d);
    s.ok  = ok;
    s.err = err;
    steps.push_back(s);
  endtask

  task automatic fill_table();
    add_step(OP_INIT,     "a1", "a1", 1'b0, 1'b0);
    add_step(OP_MOVE,     "e2", "e3", 1'b1, 1'b0);  // Pawn step
    add_step(OP_MOVE,     "d7", "d6", 1'b1, 1'b0);
    add_step(OP_MOVE,     "b1", "c3", 1'b1, 1'b0);  // Knight
    add_step(OP_MOVE,     "d6", "d5", 1'b1, 1'b0);
    add_step(OP_MOVE,     "f1", "b5", 1'b1, 1'b0);  // Bishop
    add_step(OP_MOVE,     "d5", "d4", 1'b1, 1'b0);
    add_step(OP_MOVE,     "e3", "d4", 1'b1, 1'b0);  // Pawn takes diagonally
    add_step(OP_MOVE,     "a7", "a6", 1'b1, 1'b0);
    add_step(OP_MOVE,     "a1", "a5", 1'b1, 1'b0);  // Rook
    add_step(OP_MOVE,     "g8", "f6", 1'b1, 1'b0);
    add_step(OP_MOVE,     "d1", "d3", 1'b1, 1'b0);  // Queen
    add_step(OP_MOVE,     "d8", "d5", 1'b1, 1'b0);
    add_step(OP_SQUARE,   "a5", "a1", 1'b0, 1'b0);
    add_step(OP_MOVE,     "h7", "h6", 1'b0, 1'b0);  // Opponent piece
    add_step(OP_MOVE,     "a5", "a2", 1'b0, 1'b0);  // Onto own pawn
    add_step(OP_MOVE,     "c3", "c5", 1'b0, 1'b0);  // Not a knight shape
    add_step(OP_MOVE,     "d4", "d5", 1'b0, 1'b0);  // Pawn blocked by queen
    add_step(OP_MOVE,     "e4", "e5", 1'b0, 1'b0);  // Empty origin
    add_step(OP_MOVE,     "e1", "e2", 1'b1, 1'b0);  // King
    add_step(OP_BURST,    "h7", "h6", 1'b1, 1'b1);
    add_step(OP_UNMAPPED, "a1", "a1", 1'b0, 1'b1);
    add_step(OP_MOVE,     "b5", "e8", 1'b1, 1'b0);  // Bishop takes the king
    add_step(OP_MOVE,     "g7", "g6", 1'b0, 1'b1);  // Game is over
    add_step(OP_STATUS,   "a1", "a1", 1'b0, 1'b0);
    add_step(OP_INIT,     "a1", "a1", 1'b0, 1'b0);
    add_step(OP_MOVE,     "e2", "e3", 1'b1, 1'b0);
    add_step(OP_STATUS,   "a1", "a1", 1'b0, 1'b0);
  endtask

  initial begin
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    seed    = 67128;
    for (int i = 0; i < 64; i++) begin
      ref_board[i].code = 4'h0;
    end
    ref_player = 1'b1;
    ref_ok     = 1'b0;
    ref_over   = 1'b0;
    ref_winner = 1'b0;
    fill_table();
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    verify_status();
    verify_board_random();  // Empty out of reset
    foreach (steps[i]) begin
      run_step(i, steps[i]);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
src/chess_pkg.sv
src/move_if.sv
src/apb_cmd_regs.sv
src/move_check.sv
src/board_update.sv
src/board_memory.sv
src/chess_board_top.sv
dv/chess_tb.sv

//--- src/apb_cmd_regs.sv
// APB command and status registers
`timescale 1ns/1ps
`default_nettype none

module apb_cmd_regs import chess_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [11:0] paddr,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [31:0] pwdata,
  output logic      [31:0] prdata,
  output logic             pready,
  output logic             pslverr,
  move_if.src              cmd,
  output sq_idx_t          host_addr,
  input  wire square_u     host_data,
  input  wire logic        done,
  input  wire logic        current_player,
  input  wire logic        last_ok,
  input  wire logic        game_over,
  input  wire logic        winner
);

  logic        access;
  logic        ctrl_hit;
  logic        move_hit;
  logic        status_hit;
  logic        board_hit;
  logic        mapped;
  logic        busy;
  logic        rd_wait;     // Second cycle of a board read
  logic        issue_init;
  logic        issue_move;
  logic [31:0] status_word;

  assign access     = psel & penable;
  assign ctrl_hit   = (paddr == REG_CTRL);
  assign move_hit   = (paddr == REG_MOVE);
  assign status_hit = (paddr == REG_STATUS);
  assign board_hit  = (paddr[11:8] == REG_BOARD_BASE[11:8]) && (paddr[1:0] == 2'b00);

  // CTRL and MOVE are write only, STATUS and the board read only
  assign mapped = pwrite ? (ctrl_hit | move_hit) : (status_hit | board_hit);

  assign host_addr = paddr[7:2];  // Word index into the board window

  // One wait state for board reads only
  assign pready = access & (pwrite | ~board_hit | rd_wait);

  assign pslverr = access & pready &
                   (~mapped | (pwrite & busy) | (pwrite & move_hit & game_over));

  // New work only from an idle pipeline
  assign issue_init = access & pwrite & ctrl_hit & pwdata[0] & ~busy;
  assign issue_move = access & pwrite & move_hit & ~busy & ~game_over;

  always_comb begin
    status_word            = '0;
    status_word[ST_PLAYER] = current_player;
    status_word[ST_BUSY]   = busy;
    status_word[ST_OK]     = last_ok;
    status_word[ST_OVER]   = game_over;
    status_word[ST_WINNER] = winner;
  end

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (status_hit) begin
        prdata = status_word;
      end else if (board_hit) begin
        prdata = {28'd0, host_data.code};  // Square code, zero-extended
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      rd_wait   <= 1'b0;
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= issue_init | issue_move;
      if (issue_init || issue_move) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      rd_wait <= access & ~pwrite & board_hit & ~rd_wait;
    end
  end

  // Command payload, held until the next issue
  always_ff @(posedge clk) begin
    if (issue_init || issue_move) begin
      cmd.kind_init <= issue_init;
      cmd.origin    <= pwdata[5:0];
      cmd.dest      <= pwdata[11:6];
    end
  end

  // Squares and verdict are filled in further down the pipeline
  assign cmd.piece    = '0;
  assign cmd.captured = '0;
  assign cmd.result   = RES_NONE;

endmodule

`default_nettype wire

//--- src/board_memory.sv
// Board square register file
`timescale 1ns/1ps
`default_nettype none

module board_memory import chess_pkg::*; (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    wr_en,
  input  wire sq_idx_t wr_addr,
  input  wire square_u wr_data,
  input  wire sq_idx_t rd_addr_a,   // Origin read for the check stage
  output square_u      rd_data_a,
  input  wire sq_idx_t rd_addr_b,   // Destination read
  output square_u      rd_data_b,
  input  wire sq_idx_t host_addr,   // APB board window
  output square_u      host_data
);

  square_u squares [64];

  // Empty board out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 64; i++) begin
        squares[i] <= '0;
      end
    end else if (wr_en) begin
      squares[wr_addr] <= wr_data;
    end
  end

  // All reads one cycle behind the address
  always_ff @(posedge clk) begin
    rd_data_a <= squares[rd_addr_a];
    rd_data_b <= squares[rd_addr_b];
    host_data <= squares[host_addr];
  end

endmodule

`default_nettype wire

//--- src/board_update.sv
// Board update and game state
`timescale 1ns/1ps
`default_nettype none

module board_update import chess_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  move_if.dst       upd,
  output logic      wr_en,
  output sq_idx_t   wr_addr,
  output square_u   wr_data,
  output logic      done,
  output logic      current_player,
  output logic      last_ok,
  output logic      game_over,
  output logic      winner
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_DST  = 2'd1;
  localparam logic [1:0] S_ORG  = 2'd2;
  localparam logic [1:0] S_INIT = 2'd3;

  logic [1:0] state;
  logic [5:0] init_cnt;   // Square being written during init
  sq_idx_t    org_q;
  sq_idx_t    dst_q;
  square_u    piece_q;
  square_u    captured_q;
  logic       ok_q;
  logic [2:0] back_kind;
  square_u    start_sq;

  // Start position from file and rank
  always_comb begin
    case (init_cnt[5:3])
      3'd0, 3'd7: back_kind = KIND_ROOK;
      3'd1, 3'd6: back_kind = KIND_KNIGHT;
      3'd2, 3'd5: back_kind = KIND_BISHOP;
      3'd3:       back_kind = KIND_QUEEN;
      default:    back_kind = KIND_KING;
    endcase
    start_sq.code = 4'h0;
    case (init_cnt[2:0])
      3'd0: begin
        start_sq.pc.white = 1'b1;
        start_sq.pc.kind  = back_kind;
      end
      3'd1: begin
        start_sq.pc.white = 1'b1;
        start_sq.pc.kind  = KIND_PAWN;
      end
      3'd6: start_sq.pc.kind = KIND_PAWN;  // Black pawns
      3'd7: start_sq.pc.kind = back_kind;
      default: start_sq.code = 4'h0;
    endcase
  end

  always_comb begin
    wr_en   = 1'b0;
    wr_addr = dst_q;
    wr_data = piece_q;
    case (state)
      S_DST: wr_en = ok_q;
      S_ORG: begin
        wr_en        = ok_q;
        wr_addr      = org_q;
        wr_data.code = 4'h0;  // Origin left empty
      end
      S_INIT: begin
        wr_en   = 1'b1;
        wr_addr = init_cnt;
        wr_data = start_sq;
      end
      default: wr_en = 1'b0;
    endcase
  end

  assign done = (state == S_ORG) || ((state == S_INIT) && (init_cnt == 6'd63));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state          <= S_IDLE;
      init_cnt       <= '0;
      current_player <= 1'b1;  // White opens
      last_ok        <= 1'b0;
      game_over      <= 1'b0;
      winner         <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (upd.valid && upd.kind_init) begin
            state          <= S_INIT;
            init_cnt       <= '0;
            current_player <= 1'b1;
            game_over      <= 1'b0;
            winner         <= 1'b0;
          end else if (upd.valid) begin
            state <= S_DST;
          end
        end
        S_DST: state <= S_ORG;
        S_ORG: begin
          state   <= S_IDLE;
          last_ok <= ok_q;
          if (ok_q) begin
            current_player <= ~current_player;
            if (captured_q.pc.kind == KIND_KING) begin
              game_over <= 1'b1;
              winner    <= current_player;  // Mover took the king
            end
          end
        end
        default: begin
          init_cnt <= init_cnt + 6'd1;
          if (init_cnt == 6'd63) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && upd.valid) begin
      org_q      <= upd.origin;
      dst_q      <= upd.dest;
      piece_q    <= upd.piece;
      captured_q <= upd.captured;
      ok_q       <= (upd.result == RES_ACCEPT);
    end
  end

endmodule

`default_nettype wire

//--- src/chess_board_top.sv
// Chess board model top level
`timescale 1ns/1ps
`default_nettype none

module chess_board_top import chess_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [11:0] paddr,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [31:0] pwdata,
  output logic      [31:0] prdata,
  output logic             pready,
  output logic             pslverr
);

  move_if cmd_link ();  // Command capture to legality check
  move_if upd_link ();  // Legality check to board update

  logic    wr_en;
  sq_idx_t wr_addr;
  square_u wr_data;
  sq_idx_t rd_addr_a;
  sq_idx_t rd_addr_b;
  square_u rd_data_a;
  square_u rd_data_b;
  sq_idx_t host_addr;
  square_u host_data;
  logic    done;
  logic    current_player;
  logic    last_ok;
  logic    game_over;
  logic    winner;

  apb_cmd_regs i_apb_cmd_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .paddr          (paddr),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .cmd            (cmd_link.src),
    .host_addr      (host_addr),
    .host_data      (host_data),
    .done           (done),
    .current_player (current_player),
    .last_ok        (last_ok),
    .game_over      (game_over),
    .winner         (winner)
  );

  move_check i_move_check (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd            (cmd_link.dst),
    .upd            (upd_link.src),
    .rd_addr_a      (rd_addr_a),
    .rd_addr_b      (rd_addr_b),
    .rd_data_a      (rd_data_a),
    .rd_data_b      (rd_data_b),
    .current_player (current_player)
  );

  board_update i_board_update (
    .clk            (clk),
    .rst_n          (rst_n),
    .upd            (upd_link.dst),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .done           (done),
    .current_player (current_player),
    .last_ok        (last_ok),
    .game_over      (game_over),
    .winner         (winner)
  );

  board_memory i_board_memory (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr_a (rd_addr_a),
    .rd_data_a (rd_data_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_b (rd_data_b),
    .host_addr (host_addr),
    .host_data (host_data)
  );

endmodule

`default_nettype wire

//--- src/chess_pkg.sv
// Chess board shared definitions
`default_nettype none

package chess_pkg;

  // Square index, file in [5:3] and rank in [2:0], a1 is 0
  typedef logic [5:0] sq_idx_t;

  // One board square, seen as a raw code or as colour over kind
  typedef union packed {
    logic [3:0] code;
    struct packed {
      logic       white;  // 1 for a white piece
      logic [2:0] kind;
    } pc;
  } square_u;

  localparam logic [2:0] KIND_EMPTY  = 3'd0;
  localparam logic [2:0] KIND_PAWN   = 3'd1;
  localparam logic [2:0] KIND_KNIGHT = 3'd2;
  localparam logic [2:0] KIND_BISHOP = 3'd3;
  localparam logic [2:0] KIND_ROOK   = 3'd4;
  localparam logic [2:0] KIND_QUEEN  = 3'd5;
  localparam logic [2:0] KIND_KING   = 3'd6;

  // APB register map
  localparam logic [11:0] REG_CTRL       = 12'h000;
  localparam logic [11:0] REG_MOVE       = 12'h004;
  localparam logic [11:0] REG_STATUS     = 12'h008;
  localparam logic [11:0] REG_BOARD_BASE = 12'h100;

  // Status word bits
  localparam int ST_PLAYER = 0;
  localparam int ST_BUSY   = 1;
  localparam int ST_OK     = 2;
  localparam int ST_OVER   = 3;
  localparam int ST_WINNER = 4;

  // Verdict from the legality check
  localparam logic [1:0] RES_NONE   = 2'd0;
  localparam logic [1:0] RES_ACCEPT = 2'd1;
  localparam logic [1:0] RES_REJECT = 2'd2;

endpackage

`default_nettype wire

//--- src/move_check.sv
// Move legality check stage
`timescale 1ns/1ps
`default_nettype none

module move_check import chess_pkg::*; (
  input  wire logic    clk,
  input  wire logic    rst_n,
  move_if.dst          cmd,
  move_if.src          upd,
  output sq_idx_t      rd_addr_a,
  output sq_idx_t      rd_addr_b,
  input  wire square_u rd_data_a,
  input  wire square_u rd_data_b,
  input  wire logic    current_player
);

  logic              s1_valid;
  logic              s1_init;
  sq_idx_t           s1_org;
  sq_idx_t           s1_dst;
  logic signed [3:0] df;       // File delta
  logic signed [3:0] dr;       // Rank delta
  logic        [2:0] adf;
  logic        [2:0] adr;
  logic signed [3:0] fwd;      // Pawn step for the side to move
  logic              dst_empty;
  logic              own_ok;
  logic              dst_ok;
  logic              shape_ok;
  logic              legal;

  // The command stage holds origin and dest stable while busy
  assign rd_addr_a = cmd.origin;
  assign rd_addr_b = cmd.dest;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= cmd.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.valid) begin
      s1_init <= cmd.kind_init;
      s1_org  <= cmd.origin;
      s1_dst  <= cmd.dest;
    end
  end

  assign df  = $signed({1'b0, s1_dst[5:3]}) - $signed({1'b0, s1_org[5:3]});
  assign dr  = $signed({1'b0, s1_dst[2:0]}) - $signed({1'b0, s1_org[2:0]});
  assign adf = df[3] ? 3'(-df) : 3'(df);
  assign adr = dr[3] ? 3'(-dr) : 3'(dr);
  assign fwd = current_player ? 4'sd1 : -4'sd1;  // White moves up the ranks

  assign dst_empty = (rd_data_b.pc.kind == KIND_EMPTY);
  assign own_ok    = (rd_data_a.pc.kind != KIND_EMPTY) &&
                     (rd_data_a.pc.white == current_player);
  assign dst_ok    = dst_empty || (rd_data_b.pc.white != current_player);

  // Shape per kind, no path blocking
  always_comb begin
    case (rd_data_a.pc.kind)
      KIND_PAWN: begin
        shape_ok = (dr == fwd) &&
                   (((adf == 3'd0) && dst_empty) || ((adf == 3'd1) && !dst_empty));
      end
      KIND_KNIGHT: begin
        shape_ok = ((adf == 3'd1) && (adr == 3'd2)) || ((adf == 3'd2) && (adr == 3'd1));
      end
      KIND_BISHOP: shape_ok = (adf == adr) && (adf != 3'd0);
      KIND_ROOK:   shape_ok = (adf == 3'd0) != (adr == 3'd0);
      KIND_QUEEN: begin
        shape_ok = ((adf == adr) && (adf != 3'd0)) || ((adf == 3'd0) != (adr == 3'd0));
      end
      KIND_KING: begin
        shape_ok = (adf <= 3'd1) && (adr <= 3'd1) && ((adf | adr) != 3'd0);
      end
      default: shape_ok = 1'b0;
    endcase
  end

  assign legal = own_ok & dst_ok & shape_ok;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      upd.valid <= 1'b0;
    end else begin
      upd.valid <= s1_valid;
    end
  end

  // Verdict and squares for the update stage
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      upd.kind_init <= s1_init;
      upd.origin    <= s1_org;
      upd.dest      <= s1_dst;
      upd.piece     <= rd_data_a;
      upd.captured  <= rd_data_b;
      if (s1_init) begin
        upd.result <= RES_NONE;  // Init passes through unchecked
      end else begin
        upd.result <= legal ? RES_ACCEPT : RES_REJECT;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/move_if.sv
// Move link between pipeline stages
`timescale 1ns/1ps
`default_nettype none

interface move_if import chess_pkg::*; ();

  logic       valid;      // One-cycle transfer strobe
  logic       kind_init;  // Board init rather than a move
  sq_idx_t    origin;
  sq_idx_t    dest;
  square_u    piece;      // Square read at the origin
  square_u    captured;   // Square read at the destination
  logic [1:0] result;

  // Sending stage
  modport src (
    output valid, kind_init, origin, dest, piece, captured, result
  );

  // Receiving stage
  modport dst (
    input valid, kind_init, origin, dest, piece, captured, result
  );

endinterface

`default_nettype wire
